//--- verilog.f
+incdir+verilog
verilog/ilk_avl_pkg.sv
verilog/ilk_rx_capture.sv
verilog/ilk_eop_decode.sv
verilog/avl_frame_tracker.sv
verilog/ilk_to_avalon_top.sv
verif/ilk_to_avalon_tb.sv

//--- Bender.yml
package:
  name: ilk_to_avalon

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ilk_avl_pkg.sv
      - verilog/ilk_rx_capture.sv
      - verilog/ilk_eop_decode.sv
      - verilog/avl_frame_tracker.sv
      - verilog/ilk_to_avalon_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/ilk_to_avalon_tb.sv

//--- verif/ilk_to_avalon_tb.sv
// Testbench for the Interlaken to Avalon receive adapter
//   stimulus table with expected Avalon control fields
//   random data words, masked copy as expected data
//   two-deep expectation line matching the DUT latency
//   typed compare tasks, cycle-count timeout
`timescale 1ns/100ps
`include "ilk_avl_config.svh"

module ilk_to_avalon_tb;

   typedef struct packed {
      logic                    valid;
      logic                    sop;
      ilk_avl_pkg::word_cnt_t  num_valid;
      ilk_avl_pkg::eopbits_t   eopbits;
      logic                    exp_valid;
      logic                    exp_eop;
      logic                    exp_error;
      ilk_avl_pkg::avl_empty_t exp_empty;
   } stim_row_t;

   logic                   clk;
   logic                   rst_n;
   ilk_avl_pkg::ilk_beat_t ilk_in;
   ilk_avl_pkg::avl_beat_t avl_out;

   stim_row_t              rows[$];
   ilk_avl_pkg::avl_beat_t exp_pipe [2];  // [1] is due at the next check
   int                     cycle_cnt   = 0;
   int                     cycle_limit = 1000;

   ilk_to_avalon_top uut (
      .clk     (clk),
      .rst_n   (rst_n),
      .ilk_in  (ilk_in),
      .avl_out (avl_out)
   );

   always #4 clk = ~clk;  // 8 ns period

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: test did not finish within %0d clock cycles", cycle_limit);
         abort_run();
      end
   end

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on first failure");
   endtask

   task automatic report_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
      $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, act);
      abort_run();
   endtask

   task automatic check_avl_ctrl(input ilk_avl_pkg::avl_beat_t exp,
                                 input ilk_avl_pkg::avl_beat_t act);
      if (act.valid !== exp.valid)
         report_value("avl_out.valid", exp.valid, act.valid);
      if (act.sop !== exp.sop)
         report_value("avl_out.sop", exp.sop, act.sop);
      if (act.eop !== exp.eop)
         report_value("avl_out.eop", exp.eop, act.eop);
      if (act.error !== exp.error)
         report_value("avl_out.error", exp.error, act.error);
      if (act.empty !== exp.empty)
         report_value("avl_out.empty", exp.empty, act.empty);
   endtask

   task automatic check_avl_data(input ilk_avl_pkg::ilk_data_t exp,
                                 input ilk_avl_pkg::ilk_data_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns avl_out.data expected %h got %h", $time, exp, act);
         abort_run();
      end
   endtask

   function automatic ilk_avl_pkg::ilk_data_t random_data();
      ilk_avl_pkg::ilk_data_t d;
      for (int w = 0; w < `ILK_WORDS; w++)
         d[w*64 +: 64] = {$urandom, $urandom};
      return d;
   endfunction

   // words at index n and above read zero, word 0 at the top
   function automatic ilk_avl_pkg::ilk_data_t mask_words(input ilk_avl_pkg::ilk_data_t d,
                                                         input ilk_avl_pkg::word_cnt_t n);
      ilk_avl_pkg::ilk_data_t m;
      int                     lsb;
      m = d;
      for (int w = 0; w < `ILK_WORDS; w++) begin
         lsb = (`ILK_WORDS - 1 - w) * 64;
         if (w >= n)
            m[lsb +: 64] = 64'h0;
      end
      return m;
   endfunction

   task automatic add_row(input logic v, input logic s, input ilk_avl_pkg::word_cnt_t n,
                          input ilk_avl_pkg::eopbits_t code, input logic ev,
                          input logic eeop, input logic eerr,
                          input ilk_avl_pkg::avl_empty_t eempty);
      stim_row_t r;
      r = '{valid: v, sop: s, num_valid: n, eopbits: code,
            exp_valid: ev, exp_eop: eeop, exp_error: eerr, exp_empty: eempty};
      rows.push_back(r);
   endtask

   task automatic build_table();
      //       v  s  n  code     val eop err empty
      // idle beats, nothing comes out
      add_row(0, 0, 8, 4'b0000, 0, 0, 0, 0);
      add_row(1, 1, 0, 4'b1000, 0, 0, 0, 0);
      add_row(1, 1, 9, 4'b1000, 0, 0, 0, 0);
      // multi-beat packet of full beats, with a gap
      add_row(1, 1, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 0, 8, 4'b0000, 1, 0, 0, 0);
      add_row(0, 0, 8, 4'b0000, 0, 0, 0, 0);
      add_row(1, 0, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 0, 8, 4'b1000, 1, 1, 0, 0);
      // single full beats, every tail byte count
      add_row(1, 1, 8, 4'b1001, 1, 1, 0, 7);
      add_row(1, 1, 8, 4'b1010, 1, 1, 0, 6);
      add_row(1, 1, 8, 4'b1011, 1, 1, 0, 5);
      add_row(1, 1, 8, 4'b1100, 1, 1, 0, 4);
      add_row(1, 1, 8, 4'b1101, 1, 1, 0, 3);
      add_row(1, 1, 8, 4'b1110, 1, 1, 0, 2);
      add_row(1, 1, 8, 4'b1111, 1, 1, 0, 1);
      // partial last beats
      add_row(1, 1, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 0, 1, 4'b1000, 1, 1, 0, 56);
      add_row(1, 1, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 0, 3, 4'b1101, 1, 1, 0, 43);
      add_row(1, 1, 7, 4'b1011, 1, 1, 0, 13);
      add_row(1, 1, 5, 4'b1111, 1, 1, 0, 25);
      add_row(1, 1, 2, 4'b1010, 1, 1, 0, 54);
      add_row(1, 1, 4, 4'b1000, 1, 1, 0, 32);
      add_row(1, 1, 6, 4'b1001, 1, 1, 0, 23);
      add_row(1, 1, 1, 4'b1001, 1, 1, 0, 63);
      // error ends, then a non-end beat that still reports empty
      add_row(1, 1, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 0, 8, 4'b0001, 1, 1, 1, 0);
      add_row(1, 1, 4, 4'b0100, 1, 1, 1, 0);
      add_row(1, 1, 3, 4'b0000, 1, 0, 0, 40);
      add_row(1, 0, 8, 4'b1000, 1, 1, 0, 0);
      // framing: beats outside a packet are dropped
      add_row(1, 0, 3, 4'b0000, 0, 0, 0, 0);
      add_row(1, 0, 8, 4'b1000, 0, 0, 0, 0);
      add_row(1, 0, 2, 4'b0001, 0, 0, 0, 0);
      // sop inside an open packet is flagged and reopens
      add_row(1, 1, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 1, 8, 4'b0000, 1, 0, 1, 0);
      add_row(1, 0, 0, 4'b0000, 0, 0, 0, 0);
      add_row(1, 0, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 0, 2, 4'b1000, 1, 1, 0, 48);
      add_row(1, 1, 8, 4'b0000, 1, 0, 0, 0);
      add_row(1, 1, 8, 4'b1000, 1, 1, 1, 0);   // eop closes it
      add_row(1, 0, 8, 4'b0000, 0, 0, 0, 0);
      // back-to-back single-beat packets
      add_row(1, 1, 8, 4'b1000, 1, 1, 0, 0);
      add_row(1, 1, 4, 4'b1100, 1, 1, 0, 36);
      add_row(1, 1, 8, 4'b0001, 1, 1, 1, 0);
      add_row(0, 0, 0, 4'b0000, 0, 0, 0, 0);
   endtask

   task automatic build_beat(input stim_row_t r, output ilk_avl_pkg::ilk_beat_t beat,
                             output ilk_avl_pkg::avl_beat_t exp);
      ilk_avl_pkg::ilk_data_t d;
      d = random_data();
      beat = '{valid: r.valid, sop: r.sop, num_valid: r.num_valid,
               eopbits: r.eopbits, data: d};
      exp = '{valid: r.exp_valid, sop: r.sop, eop: r.exp_eop, error: r.exp_error,
              empty: r.exp_empty, data: mask_words(d, r.num_valid)};
   endtask

   // one falling edge: check the beat due now, then drive the next
   task automatic run_cycle(input ilk_avl_pkg::ilk_beat_t beat,
                            input ilk_avl_pkg::avl_beat_t exp);
      @(negedge clk);
      check_avl_ctrl(exp_pipe[1], avl_out);
      if (exp_pipe[1].valid)
         check_avl_data(exp_pipe[1].data, avl_out.data);
      exp_pipe[1] = exp_pipe[0];
      exp_pipe[0] = exp;
      ilk_in      = beat;
   endtask

   initial begin
      ilk_avl_pkg::ilk_beat_t beat;
      ilk_avl_pkg::avl_beat_t exp;
      void'($urandom(60));
      clk         = 1'b0;
      rst_n       = 1'b0;
      ilk_in      = '0;
      exp_pipe[0] = '0;
      exp_pipe[1] = '0;
      build_table();
      cycle_limit = 10 + rows.size() + 2 + 20;

      // control outputs stay low while reset is held
      repeat (10) begin
         @(negedge clk);
         check_avl_ctrl('0, avl_out);
      end
      rst_n = 1'b1;

      foreach (rows[i]) begin
         build_beat(rows[i], beat, exp);
         run_cycle(beat, exp);
      end

      // flush the last two beats
      repeat (2)
         run_cycle('0, '0);

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- verilog/ilk_to_avalon_top.sv
// Interlaken to Avalon receive adapter, top level
//   capture register -> end decoder -> framing and output register
// two cycles from ilk_in to avl_out, no back-pressure
`timescale 1ns/100ps

module ilk_to_avalon_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ilk_avl_pkg::ilk_beat_t ilk_in,
   output ilk_avl_pkg::avl_beat_t avl_out
);

   ilk_avl_pkg::ilk_beat_t cap_beat;  // registered, masked input
   ilk_avl_pkg::avl_beat_t dec_beat;  // decoded, same cycle

   ilk_rx_capture u_capture (
      .clk      (clk),
      .rst_n    (rst_n),
      .ilk_in   (ilk_in),
      .cap_beat (cap_beat)
   );

   ilk_eop_decode u_decode (
      .cap_beat (cap_beat),
      .dec_beat (dec_beat)
   );

   avl_frame_tracker u_tracker (
      .clk      (clk),
      .rst_n    (rst_n),
      .dec_beat (dec_beat),
      .avl_out  (avl_out)
   );

endmodule

//--- verilog/avl_frame_tracker.sv
// Avalon packet framing and output register
//   FSM follows sop/eop of forwarded beats
//   drops beats outside a packet that carry no sop
//   flags a sop arriving inside an open packet as an error
`timescale 1ns/100ps

module avl_frame_tracker (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ilk_avl_pkg::avl_beat_t dec_beat,
   output ilk_avl_pkg::avl_beat_t avl_out
);

   ilk_avl_pkg::frame_state_e state_q;
   ilk_avl_pkg::frame_state_e state_d;

   logic fwd;        // beat goes out this cycle
   logic early_sop;  // sop while a packet is still open

   logic                    valid_q;
   logic                    sop_q;
   logic                    eop_q;
   logic                    error_q;
   ilk_avl_pkg::avl_empty_t empty_q;
   ilk_avl_pkg::ilk_data_t  data_q;

   assign fwd = dec_beat.valid && (dec_beat.sop || state_q == ilk_avl_pkg::FRAME_IN_PKT);

   assign early_sop = dec_beat.valid && dec_beat.sop &&
                      (state_q == ilk_avl_pkg::FRAME_IN_PKT);

   always_comb begin
      state_d = state_q;
      if (fwd) begin
         if (dec_beat.eop)
            state_d = ilk_avl_pkg::FRAME_IDLE;   // eop wins over sop
         else if (dec_beat.sop)
            state_d = ilk_avl_pkg::FRAME_IN_PKT;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ilk_avl_pkg::FRAME_IDLE;
         valid_q <= 1'b0;
         sop_q   <= 1'b0;
         eop_q   <= 1'b0;
         error_q <= 1'b0;
         empty_q <= '0;
      end else begin
         state_q <= state_d;
         valid_q <= fwd;
         sop_q   <= dec_beat.sop;  // passes like the decoder does
         // dropped beats carry no eop, error or empty
         eop_q   <= fwd & dec_beat.eop;
         error_q <= fwd & (dec_beat.error | early_sop);
         empty_q <= fwd ? dec_beat.empty : '0;
      end
   end

   always_ff @(posedge clk) begin
      data_q <= dec_beat.data;
   end

   assign avl_out = '{
      valid: valid_q,
      sop:   sop_q,
      eop:   eop_q,
      error: error_q,
      empty: empty_q,
      data:  data_q
   };

endmodule

//--- verilog/ilk_eop_decode.sv
// End-of-packet decoder, Interlaken word count and end code to Avalon
//   valid, eop, error and empty from num_valid and eopbits
//   sop and data pass straight through
// empty = 8 * unused words, plus unused bytes of the last word on a 1bbb end
`timescale 1ns/100ps
`include "ilk_avl_config.svh"

module ilk_eop_decode (
   input  ilk_avl_pkg::ilk_beat_t cap_beat,
   output ilk_avl_pkg::avl_beat_t dec_beat
);

   logic                    cnt_ok;     // 1..ILK_WORDS
   logic [2:0]              tail_bytes; // valid bytes in last word, 0 = all
   ilk_avl_pkg::avl_empty_t pad_bytes;  // bytes of the unused words
   ilk_avl_pkg::avl_empty_t tail_pad;   // unused bytes inside last word

   assign cnt_ok = (cap_beat.num_valid != '0) && (cap_beat.num_valid <= `ILK_WORDS);

   assign tail_bytes = cap_beat.eopbits[2:0];

   // only meaningful when cnt_ok, result fits the empty width
   assign pad_bytes = ilk_avl_pkg::avl_empty_t'((`ILK_WORDS - cap_beat.num_valid) * 8);

   assign tail_pad = (tail_bytes == 3'd0) ? '0 :
                     ilk_avl_pkg::avl_empty_t'(4'd8 - {1'b0, tail_bytes});

   always_comb begin
      dec_beat.sop   = cap_beat.sop;
      dec_beat.data  = cap_beat.data;
      dec_beat.valid = 1'b0;
      dec_beat.eop   = 1'b0;
      dec_beat.error = 1'b0;
      dec_beat.empty = '0;

      if (cap_beat.valid && cnt_ok) begin
         dec_beat.valid = 1'b1;
         if (cap_beat.eopbits == 4'b0000) begin
            // no end, still reports an empty count
            dec_beat.empty = pad_bytes;
         end else if (cap_beat.eopbits[3]) begin
            dec_beat.eop   = 1'b1;
            dec_beat.empty = pad_bytes + tail_pad;
         end else begin
            // 0001 and every other code is an error end
            dec_beat.eop   = 1'b1;
            dec_beat.error = 1'b1;
         end
      end
   end

endmodule

//--- verilog/ilk_rx_capture.sv
// Input register for the Interlaken beat
//   control fields held under reset
//   data words past the valid count are zeroed on the way in
`timescale 1ns/100ps
`include "ilk_avl_config.svh"

module ilk_rx_capture (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ilk_avl_pkg::ilk_beat_t ilk_in,
   output ilk_avl_pkg::ilk_beat_t cap_beat
);

   logic                   valid_q;
   logic                   sop_q;
   ilk_avl_pkg::word_cnt_t cnt_q;
   ilk_avl_pkg::eopbits_t  eopbits_q;
   ilk_avl_pkg::ilk_data_t data_q;

   ilk_avl_pkg::ilk_data_t masked_data;
   ilk_avl_pkg::ilk_word_t word;

   // word i sits at the top of the bus for i = 0
   always_comb begin
      masked_data = '0;
      word        = '0;
      for (int i = 0; i < `ILK_WORDS; i++) begin
         word = ilk_in.data[(`ILK_WORDS-1-i)*64 +: 64];
         if (i < ilk_in.num_valid)
            masked_data[(`ILK_WORDS-1-i)*64 +: 64] = word;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q   <= 1'b0;
         sop_q     <= 1'b0;
         cnt_q     <= '0;
         eopbits_q <= '0;
      end else begin
         valid_q   <= ilk_in.valid;  // plain strobe, no ready
         sop_q     <= ilk_in.sop;
         cnt_q     <= ilk_in.num_valid;
         eopbits_q <= ilk_in.eopbits;
      end
   end

   always_ff @(posedge clk) begin
      data_q <= masked_data;
   end

   assign cap_beat = '{
      valid:     valid_q,
      sop:       sop_q,
      num_valid: cnt_q,
      eopbits:   eopbits_q,
      data:      data_q
   };

endmodule

//--- verilog/ilk_avl_pkg.sv
// Shared types for the Interlaken to Avalon receive adapter
//   data, count, end code and empty vectors
//   Interlaken and Avalon beat structs
//   framing state enum
`include "ilk_avl_config.svh"

package ilk_avl_pkg;

   typedef logic [63:0]                   ilk_word_t;  // one data word
   typedef logic [`ILK_WORDS*64-1:0]      ilk_data_t;  // word 0 in the top bits
   typedef logic [`ILK_LOG_WORDS-1:0]     word_cnt_t;
   typedef logic [`AVL_EMPTY_W-1:0]       avl_empty_t;

   // 1bbb = end, bbb valid bytes in last word (0 -> all 8)
   // 0001 = error end, 0000 = no end
   typedef logic [3:0] eopbits_t;

   // beat as it arrives from the Interlaken core
   typedef struct packed {
      logic      valid;
      logic      sop;
      word_cnt_t num_valid;
      eopbits_t  eopbits;
      ilk_data_t data;
   } ilk_beat_t;

   // beat as presented on the Avalon source
   typedef struct packed {
      logic       valid;
      logic       sop;
      logic       eop;
      logic       error;
      avl_empty_t empty;
      ilk_data_t  data;
   } avl_beat_t;

   typedef enum logic {
      FRAME_IDLE,
      FRAME_IN_PKT
   } frame_state_e;

endpackage

//--- verilog/ilk_avl_config.svh
// Build-time sizing for the Interlaken to Avalon receive adapter
//   ILK_WORDS      data words per beat
//   ILK_LOG_WORDS  width of the valid word count
//   AVL_EMPTY_W    width of the Avalon empty field
`ifndef ILK_AVL_CONFIG_SVH
`define ILK_AVL_CONFIG_SVH

// 8 x 64 bit words per beat
`define ILK_WORDS 8

// count runs 0..8, so one spare bit
`define ILK_LOG_WORDS 4

// log2 of bytes per beat (64 bytes)
`define AVL_EMPTY_W 6

`endif
